/* flist.f */
+incdir+hw
hw/demux_pkg.sv
hw/addr_remap.sv
hw/dest_decoder.sv
hw/resp_mux.sv
hw/periph_port.sv
hw/core_demux.sv
tb/tb_core_demux.sv

/* run.sh */
#!/bin/sh
# Build the core demux testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  -f flist.f --top-module tb_core_demux -o tb_core_demux &&
  ./obj_dir/tb_core_demux | tee /dev/stderr | grep -qx "TESTS PASSED" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* tb/tb_core_demux.sv */
// Core demux testbench
`timescale 1ns/10ps
`include "demux_cfg.svh"

// Bus target that grants after a delay and answers one cycle later
module target_model #(
  parameter logic [`DEMUX_DATA_WIDTH-1:0] XOR_MASK = '0,
  parameter bit                           HAS_OPC  = 1'b0
) (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic [`DEMUX_ADDR_WIDTH-1:0] addr_i,
  input  logic [1:0]                   delay_i,
  output logic                         gnt_o,
  output logic                         r_valid_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] r_rdata_o,
  output logic                         r_opc_o
);

  logic [2:0] wait_q;

  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q    <= '0;
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
      r_opc_o   <= 1'b0;
    end else begin
      r_valid_o <= 1'b0;
      if (req_i && gnt_o) begin
        gnt_o     <= 1'b0;
        wait_q    <= '0;
        r_valid_o <= 1'b1;
        r_rdata_o <= addr_i ^ XOR_MASK;
        r_opc_o   <= HAS_OPC & addr_i[2];
      end else if (req_i && (wait_q == {1'b0, delay_i})) begin
        gnt_o <= 1'b1;
      end else if (req_i) begin
        wait_q <= wait_q + 3'd1;
      end
    end
  end

endmodule

module tb_core_demux;

  import demux_pkg::*;

  localparam int NUM_ROWS     = 18;
  localparam int RESET_CYCLES = 10;
  localparam int ROW_LIMIT    = 30;
  localparam logic [`DEMUX_DATA_WIDTH-1:0] SH_MASK  = 32'h5a5a_0000;
  localparam logic [`DEMUX_DATA_WIDTH-1:0] PE_MASK  = 32'h0f0f_f0f0;
  localparam logic [`DEMUX_DATA_WIDTH-1:0] EXT_MASK = 32'hc3c3_3c3c;

  logic                         clk, rst_ni, data_req_i, data_wen_i;
  logic [`DEMUX_BASE_WIDTH-1:0] base_addr_i;
  logic [`DEMUX_CID_WIDTH-1:0]  cluster_id_i;
  logic [`DEMUX_ADDR_WIDTH-1:0] data_add_i, data_add_sh_o, data_add_pe_o, data_add_ext_o;
  logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_i, data_wdata_sh_o, data_wdata_pe_o;
  logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_ext_o, data_r_rdata_o, data_r_rdata_sh_i;
  logic [`DEMUX_DATA_WIDTH-1:0] data_r_rdata_pe_i, data_r_rdata_ext_i;
  logic [`DEMUX_BE_WIDTH-1:0]   data_be_i, data_be_sh_o, data_be_pe_o, data_be_ext_o;
  logic data_gnt_o, data_r_valid_o, data_r_opc_o;
  logic data_req_sh_o, data_wen_sh_o, data_gnt_sh_i, data_r_valid_sh_i;
  logic data_req_pe_o, data_wen_pe_o, data_gnt_pe_i, data_r_valid_pe_i, data_r_opc_pe_i;
  logic data_req_ext_o, data_wen_ext_o, data_gnt_ext_i, data_r_valid_ext_i, data_r_opc_ext_i;
  logic perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;
  logic [1:0]  gnt_delay;
  logic [31:0] rng_state;
  int          err_cnt;
  int          rows_failed;
  int          row_cnt;

  // Stimulus table with one core request per row
  logic [`DEMUX_CID_WIDTH-1:0]  tab_cid   [NUM_ROWS];
  logic [`DEMUX_BASE_WIDTH-1:0] tab_base  [NUM_ROWS];
  logic [`DEMUX_ADDR_WIDTH-1:0] tab_addr  [NUM_ROWS];
  logic                         tab_wen   [NUM_ROWS];
  logic [`DEMUX_DATA_WIDTH-1:0] tab_wdata [NUM_ROWS];
  dest_e                        tab_dest  [NUM_ROWS];
  logic [`DEMUX_ADDR_WIDTH-1:0] tab_exp   [NUM_ROWS];

  core_demux UUT (.*);

  target_model #(.XOR_MASK(SH_MASK), .HAS_OPC(1'b0)) i_sh_model (
    .clk, .rst_ni, .req_i(data_req_sh_o), .addr_i(data_add_sh_o), .delay_i(gnt_delay),
    .gnt_o(data_gnt_sh_i), .r_valid_o(data_r_valid_sh_i), .r_rdata_o(data_r_rdata_sh_i),
    .r_opc_o()
  );
  target_model #(.XOR_MASK(PE_MASK), .HAS_OPC(1'b1)) i_pe_model (
    .clk, .rst_ni, .req_i(data_req_pe_o), .addr_i(data_add_pe_o), .delay_i(gnt_delay),
    .gnt_o(data_gnt_pe_i), .r_valid_o(data_r_valid_pe_i), .r_rdata_o(data_r_rdata_pe_i),
    .r_opc_o(data_r_opc_pe_i)
  );
  target_model #(.XOR_MASK(EXT_MASK), .HAS_OPC(1'b1)) i_ext_model (
    .clk, .rst_ni, .req_i(data_req_ext_o), .addr_i(data_add_ext_o), .delay_i(gnt_delay),
    .gnt_o(data_gnt_ext_i), .r_valid_o(data_r_valid_ext_i), .r_rdata_o(data_r_rdata_ext_i),
    .r_opc_o(data_r_opc_ext_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [`DEMUX_DATA_WIDTH-1:0] resp_mask(input dest_e d);
    case (d)
      DEST_PE:  return PE_MASK;
      DEST_EXT: return EXT_MASK;
      default:  return SH_MASK;
    endcase
  endfunction

  task automatic check_dest(input string name, input dest_e got, input dest_e exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input logic [`DEMUX_ADDR_WIDTH-1:0] got,
                            input logic [`DEMUX_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_data(input string name, input logic [`DEMUX_DATA_WIDTH-1:0] got,
                            input logic [`DEMUX_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_be(input string name, input logic [`DEMUX_BE_WIDTH-1:0] got,
                          input logic [`DEMUX_BE_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Payload fans out to all three targets while the core requests
  task automatic check_payload(input string tgt, input int idx,
                               input logic [`DEMUX_BE_WIDTH-1:0] exp_be,
                               input logic [`DEMUX_ADDR_WIDTH-1:0] addr, input logic wen,
                               input logic [`DEMUX_DATA_WIDTH-1:0] wdata,
                               input logic [`DEMUX_BE_WIDTH-1:0] be);
    check_addr($sformatf("data_add_%s_o", tgt), addr, tab_exp[idx]);
    check_bit($sformatf("data_wen_%s_o", tgt), wen, tab_wen[idx]);
    check_data($sformatf("data_wdata_%s_o", tgt), wdata, tab_wdata[idx]);
    check_be($sformatf("data_be_%s_o", tgt), be, exp_be);
  endtask

  task automatic add_row(input logic [5:0] cid, input logic [3:0] base, input logic [31:0] addr,
                         input logic wen, input logic [31:0] wdata, input dest_e dest,
                         input logic [31:0] exp_addr);
    tab_cid[row_cnt]   = cid;
    tab_base[row_cnt]  = base;
    tab_addr[row_cnt]  = addr;
    tab_wen[row_cnt]   = wen;
    tab_wdata[row_cnt] = wdata;
    tab_dest[row_cnt]  = dest;
    tab_exp[row_cnt]   = exp_addr;
    row_cnt++;
  endtask

  task automatic run_row(input int idx);
    int                         cyc;
    int                         gnt_cyc;
    int                         pe_rv_cyc;
    int                         rv_cyc;
    int                         ld_cnt;
    int                         st_cnt;
    int                         errs_before;
    logic                       is_l2;
    logic                       req_seen;
    logic [`DEMUX_BE_WIDTH-1:0] row_be;
    dest_e                      got_dest;
    cyc         = 0;
    gnt_cyc     = -1;
    pe_rv_cyc   = -1;
    rv_cyc      = -1;
    ld_cnt      = 0;
    st_cnt      = 0;
    errs_before = err_cnt;
    is_l2       = (tab_dest[idx] != DEST_SH);
    req_seen    = 1'b0;
    rng_state   = xorshift(rng_state);
    row_be      = rng_state[7:4];
    @(posedge clk);
    cluster_id_i <= tab_cid[idx];
    base_addr_i  <= tab_base[idx];
    data_add_i   <= tab_addr[idx];
    data_wen_i   <= tab_wen[idx];
    data_wdata_i <= tab_wdata[idx];
    data_be_i    <= row_be;
    gnt_delay    <= rng_state[1:0];
    data_req_i   <= 1'b1;
    while (rv_cyc < 0 && cyc < ROW_LIMIT) begin
      @(posedge clk);
      cyc++;
      if (!req_seen && (data_req_sh_o || data_req_pe_o || data_req_ext_o)) begin
        req_seen = 1'b1;
        if ($countones({data_req_sh_o, data_req_pe_o, data_req_ext_o}) > 1) begin
          $display("Row %0d: more than one target request is high at once", idx);
          err_cnt++;
        end
        if (data_req_ext_o) begin
          got_dest = DEST_EXT;
        end else if (data_req_pe_o) begin
          got_dest = DEST_PE;
        end else begin
          got_dest = DEST_SH;
        end
        check_dest("target request", got_dest, tab_dest[idx]);
        check_payload("sh", idx, row_be, data_add_sh_o, data_wen_sh_o,
                      data_wdata_sh_o, data_be_sh_o);
        check_payload("pe", idx, row_be, data_add_pe_o, data_wen_pe_o,
                      data_wdata_pe_o, data_be_pe_o);
        check_payload("ext", idx, row_be, data_add_ext_o, data_wen_ext_o,
                      data_wdata_ext_o, data_be_ext_o);
      end
      check_bit("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, data_req_i && is_l2 && tab_wen[idx]);
      check_bit("perf_l2_st_cyc_o", perf_l2_st_cyc_o, data_req_i && is_l2 && !tab_wen[idx]);
      if (perf_l2_ld_o) ld_cnt++;
      if (perf_l2_st_o) st_cnt++;
      if (data_r_valid_pe_i && pe_rv_cyc < 0) pe_rv_cyc = cyc;
      if (data_req_i && data_gnt_o) begin
        gnt_cyc = cyc;
        data_req_i <= 1'b0;
      end
      if (data_r_valid_o) begin
        rv_cyc = cyc;
        check_data("data_r_rdata_o", data_r_rdata_o, tab_exp[idx] ^ resp_mask(tab_dest[idx]));
        check_bit("data_r_opc_o", data_r_opc_o, is_l2 ? tab_exp[idx][2] : 1'b0);
      end
    end
    if (!req_seen) begin
      $display("Row %0d: the request never reached any target", idx);
      err_cnt++;
    end
    if (rv_cyc < 0) begin
      $display("Row %0d: no response reached the core within %0d cycles", idx, ROW_LIMIT);
      err_cnt++;
      data_req_i <= 1'b0;
    end else begin
      if (tab_dest[idx] == DEST_PE && gnt_cyc != pe_rv_cyc + 1) begin
        $display("Row %0d: core grant came %0d cycles after the PE response instead of 1",
                 idx, gnt_cyc - pe_rv_cyc);
        err_cnt++;
      end
      if (rv_cyc != gnt_cyc + 1) begin
        $display("Row %0d: core response came %0d cycles after the grant instead of 1",
                 idx, rv_cyc - gnt_cyc);
        err_cnt++;
      end
    end
    if (ld_cnt != ((is_l2 && tab_wen[idx]) ? 1 : 0) ||
        st_cnt != ((is_l2 && !tab_wen[idx]) ? 1 : 0)) begin
      $display("Row %0d: L2 strobes pulsed for %0d loads and %0d stores", idx, ld_cnt, st_cnt);
      err_cnt++;
    end
    if (err_cnt != errs_before) rows_failed++;
    $display("Row %0d %s %h: %s", idx, tab_dest[idx].name(), tab_addr[idx],
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_ni       = 1'b0;
    base_addr_i  = '0;
    cluster_id_i = '0;
    data_req_i   = 1'b0;
    data_add_i   = '0;
    data_wen_i   = 1'b0;
    data_wdata_i = '0;
    data_be_i    = '0;
    gnt_delay    = '0;
    rng_state    = 32'h67aa;
    err_cnt      = 0;
    rows_failed  = 0;
    row_cnt      = 0;
    // TCDM slots and peripheral region with base nibble 1 and hence no swap
    add_row(6'd0,  4'h1, 32'h1000_0010, 1'b1, 32'h0000_1111, DEST_SH,  32'h1000_0010);
    add_row(6'd0,  4'h1, 32'h1010_0024, 1'b0, 32'h2222_0000, DEST_SH,  32'h1010_0024);
    add_row(6'd5,  4'h1, 32'h1140_0100, 1'b1, 32'h0000_0000, DEST_SH,  32'h1140_0100);
    add_row(6'd5,  4'h1, 32'h1150_0208, 1'b0, 32'h3333_4444, DEST_SH,  32'h1150_0208);
    add_row(6'd5,  4'h1, 32'h1160_4004, 1'b1, 32'h0000_0000, DEST_EXT, 32'h1160_4004);
    add_row(6'd5,  4'h1, 32'h1160_4000, 1'b0, 32'h5555_6666, DEST_EXT, 32'h1160_4000);
    add_row(6'd5,  4'h1, 32'h1160_0804, 1'b1, 32'h0000_0000, DEST_PE,  32'h1160_0804);
    add_row(6'd5,  4'h1, 32'h1c00_0000, 1'b0, 32'h7777_8888, DEST_PE,  32'h1c00_0000);
    // Alias regions
    add_row(6'd9,  4'h1, 32'h0000_0040, 1'b1, 32'h0000_0000, DEST_SH,  32'h0000_0040);
    add_row(6'd9,  4'h1, 32'h0010_0080, 1'b0, 32'h9999_aaaa, DEST_SH,  32'h0010_0080);
    add_row(6'd9,  4'h1, 32'h0020_4004, 1'b1, 32'h0000_0000, DEST_EXT, 32'h0020_4004);
    add_row(6'd9,  4'h1, 32'h0020_8000, 1'b1, 32'h0000_0000, DEST_PE,  32'h0020_8000);
    // Nibble equal to base, equal to 1, and other
    add_row(6'd2,  4'ha, 32'ha080_0010, 1'b1, 32'h0000_0000, DEST_SH,  32'h1080_0010);
    add_row(6'd2,  4'ha, 32'h1080_0010, 1'b0, 32'hbbbb_cccc, DEST_PE,  32'ha080_0010);
    add_row(6'd2,  4'ha, 32'h5123_4564, 1'b1, 32'h0000_0000, DEST_PE,  32'h5123_4564);
    add_row(6'd2,  4'ha, 32'ha0a0_4008, 1'b0, 32'hdddd_eeee, DEST_EXT, 32'h10a0_4008);
    add_row(6'd63, 4'h3, 32'h3fc0_0004, 1'b1, 32'h0000_0000, DEST_SH,  32'h1fc0_0004);
    add_row(6'd63, 4'h3, 32'h3fe0_4404, 1'b1, 32'h0000_0000, DEST_PE,  32'h1fe0_4404);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("%0d rows run, %0d passed, %0d failed, %0d errors", NUM_ROWS,
             NUM_ROWS - rows_failed, rows_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Budget of 40 cycles per row after reset
  initial begin
    repeat (RESET_CYCLES + NUM_ROWS * 40) @(posedge clk);
    $display("Watchdog expired before all rows finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* hw/core_demux.sv */
// Core data port demultiplexer
`timescale 1ns/10ps
`include "demux_cfg.svh"

module core_demux (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic [`DEMUX_BASE_WIDTH-1:0] base_addr_i,
  input  logic [`DEMUX_CID_WIDTH-1:0]  cluster_id_i,

  // Core side
  input  logic                         data_req_i,
  input  logic [`DEMUX_ADDR_WIDTH-1:0] data_add_i,
  input  logic                         data_wen_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_i,
  input  logic [`DEMUX_BE_WIDTH-1:0]   data_be_i,
  output logic                         data_gnt_o,
  output logic                         data_r_valid_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] data_r_rdata_o,
  output logic                         data_r_opc_o,

  // Shared TCDM interconnect
  output logic                         data_req_sh_o,
  output logic [`DEMUX_ADDR_WIDTH-1:0] data_add_sh_o,
  output logic                         data_wen_sh_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_sh_o,
  output logic [`DEMUX_BE_WIDTH-1:0]   data_be_sh_o,
  input  logic                         data_gnt_sh_i,
  input  logic                         data_r_valid_sh_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] data_r_rdata_sh_i,

  // Peripheral interconnect
  output logic                         data_req_pe_o,
  output logic [`DEMUX_ADDR_WIDTH-1:0] data_add_pe_o,
  output logic                         data_wen_pe_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_pe_o,
  output logic [`DEMUX_BE_WIDTH-1:0]   data_be_pe_o,
  input  logic                         data_gnt_pe_i,
  input  logic                         data_r_valid_pe_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] data_r_rdata_pe_i,
  input  logic                         data_r_opc_pe_i,

  // Demux peripherals
  output logic                         data_req_ext_o,
  output logic [`DEMUX_ADDR_WIDTH-1:0] data_add_ext_o,
  output logic                         data_wen_ext_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] data_wdata_ext_o,
  output logic [`DEMUX_BE_WIDTH-1:0]   data_be_ext_o,
  input  logic                         data_gnt_ext_i,
  input  logic                         data_r_valid_ext_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] data_r_rdata_ext_i,
  input  logic                         data_r_opc_ext_i,

  // L2 performance strobes
  output logic                         perf_l2_ld_o,
  output logic                         perf_l2_st_o,
  output logic                         perf_l2_ld_cyc_o,
  output logic                         perf_l2_st_cyc_o
);

  import demux_pkg::*;

  logic [`DEMUX_ADDR_WIDTH-1:0] addr_remapped;
  dest_e                        dest;

  logic                         pe_core_req;
  logic                         pe_core_gnt;
  logic                         pe_r_valid;
  logic [`DEMUX_DATA_WIDTH-1:0] pe_r_rdata;
  logic                         pe_r_opc;

  logic                         l2_req;
  logic                         l2_gnt;

  addr_remap i_addr_remap (
    .addr_i      ( data_add_i    ),
    .base_addr_i ( base_addr_i   ),
    .addr_o      ( addr_remapped )
  );

  dest_decoder i_dest_decoder (
    .addr_i       ( addr_remapped ),
    .cluster_id_i ( cluster_id_i  ),
    .dest_o       ( dest          )
  );

  // Payload goes to every target, only the request strobe is steered
  assign data_add_sh_o    = addr_remapped;
  assign data_wen_sh_o    = data_wen_i;
  assign data_wdata_sh_o  = data_wdata_i;
  assign data_be_sh_o     = data_be_i;
  assign data_add_pe_o    = addr_remapped;
  assign data_wen_pe_o    = data_wen_i;
  assign data_wdata_pe_o  = data_wdata_i;
  assign data_be_pe_o     = data_be_i;
  assign data_add_ext_o   = addr_remapped;
  assign data_wen_ext_o   = data_wen_i;
  assign data_wdata_ext_o = data_wdata_i;
  assign data_be_ext_o    = data_be_i;

  assign data_req_sh_o  = data_req_i && (dest == DEST_SH);
  assign data_req_ext_o = data_req_i && (dest == DEST_EXT);
  assign pe_core_req    = data_req_i && (dest == DEST_PE);

  periph_port i_periph_port (
    .clk          ( clk               ),
    .rst_ni       ( rst_ni            ),
    .req_i        ( pe_core_req       ),
    .gnt_o        ( pe_core_gnt       ),
    .pe_req_o     ( data_req_pe_o     ),
    .pe_gnt_i     ( data_gnt_pe_i     ),
    .pe_r_valid_i ( data_r_valid_pe_i ),
    .pe_r_rdata_i ( data_r_rdata_pe_i ),
    .pe_r_opc_i   ( data_r_opc_pe_i   ),
    .r_valid_o    ( pe_r_valid        ),
    .r_rdata_o    ( pe_r_rdata        ),
    .r_opc_o      ( pe_r_opc          )
  );

  // Grant from whichever target the request is routed to
  assign l2_gnt     = (dest == DEST_EXT) ? data_gnt_ext_i : pe_core_gnt;
  assign data_gnt_o = (dest == DEST_SH) ? data_gnt_sh_i : l2_gnt;

  resp_mux i_resp_mux (
    .clk           ( clk                ),
    .rst_ni        ( rst_ni             ),
    .req_i         ( data_req_i         ),
    .dest_i        ( dest               ),
    .sh_r_valid_i  ( data_r_valid_sh_i  ),
    .sh_r_rdata_i  ( data_r_rdata_sh_i  ),
    .pe_r_valid_i  ( pe_r_valid         ),
    .pe_r_rdata_i  ( pe_r_rdata         ),
    .pe_r_opc_i    ( pe_r_opc           ),
    .ext_r_valid_i ( data_r_valid_ext_i ),
    .ext_r_rdata_i ( data_r_rdata_ext_i ),
    .ext_r_opc_i   ( data_r_opc_ext_i   ),
    .r_valid_o     ( data_r_valid_o     ),
    .r_rdata_o     ( data_r_rdata_o     ),
    .r_opc_o       ( data_r_opc_o       )
  );

  // L2 path covers both PE and EXT, wen high marks a load
  assign l2_req           = pe_core_req || data_req_ext_o;
  assign perf_l2_ld_o     = l2_req && l2_gnt && data_wen_i;
  assign perf_l2_st_o     = l2_req && l2_gnt && !data_wen_i;
  assign perf_l2_ld_cyc_o = l2_req && data_wen_i;
  assign perf_l2_st_cyc_o = l2_req && !data_wen_i;

endmodule

/* hw/periph_port.sv */
// Peripheral interconnect port
`timescale 1ns/10ps
`include "demux_cfg.svh"

module periph_port (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic                         req_i,
  output logic                         gnt_o,
  output logic                         pe_req_o,
  input  logic                         pe_gnt_i,
  input  logic                         pe_r_valid_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] pe_r_rdata_i,
  input  logic                         pe_r_opc_i,
  output logic                         r_valid_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] r_rdata_o,
  output logic                         r_opc_o
);

  import demux_pkg::*;

  pe_state_e state_q;
  pe_state_e state_d;

  // First response stage
  logic                         s0_valid_q;
  logic [`DEMUX_DATA_WIDTH-1:0] s0_rdata_q;
  logic                         s0_opc_q;

  // Second response stage, seen by the core
  logic                         s1_valid_q;
  logic [`DEMUX_DATA_WIDTH-1:0] s1_rdata_q;
  logic                         s1_opc_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The core grant is held back until the peripheral has answered
  always_comb begin
    state_d  = state_q;
    pe_req_o = 1'b0;
    gnt_o    = 1'b0;
    case (state_q)
      PE_IDLE: begin
        pe_req_o = req_i;
        if (req_i && pe_gnt_i) begin
          state_d = PE_PENDING;
        end
      end
      PE_PENDING: begin
        if (pe_r_valid_i) begin
          state_d = PE_GRANTED;
        end
      end
      PE_GRANTED: begin
        gnt_o   = 1'b1;
        state_d = PE_IDLE;
      end
      default: begin
        state_d = PE_IDLE;
      end
    endcase
  end

  // Response lands on the core one cycle after its grant
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      s0_valid_q <= 1'b0;
      s0_rdata_q <= '0;
      s0_opc_q   <= 1'b0;
      s1_valid_q <= 1'b0;
      s1_rdata_q <= '0;
      s1_opc_q   <= 1'b0;
    end else begin
      s0_valid_q <= pe_r_valid_i;
      if (pe_r_valid_i) begin
        s0_rdata_q <= pe_r_rdata_i;
        s0_opc_q   <= pe_r_opc_i;
      end
      s1_valid_q <= s0_valid_q;
      if (s0_valid_q) begin
        s1_rdata_q <= s0_rdata_q;
        s1_opc_q   <= s0_opc_q;
      end
    end
  end

  assign r_valid_o = s1_valid_q;
  assign r_rdata_o = s1_rdata_q;
  assign r_opc_o   = s1_opc_q;

endmodule

/* hw/resp_mux.sv */
// Response multiplexer
`timescale 1ns/10ps
`include "demux_cfg.svh"

module resp_mux (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  demux_pkg::dest_e             dest_i,
  input  logic                         sh_r_valid_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] sh_r_rdata_i,
  input  logic                         pe_r_valid_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] pe_r_rdata_i,
  input  logic                         pe_r_opc_i,
  input  logic                         ext_r_valid_i,
  input  logic [`DEMUX_DATA_WIDTH-1:0] ext_r_rdata_i,
  input  logic                         ext_r_opc_i,
  output logic                         r_valid_o,
  output logic [`DEMUX_DATA_WIDTH-1:0] r_rdata_o,
  output logic                         r_opc_o
);

  import demux_pkg::*;

  dest_e dest_q;

  // Track where the current request went
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dest_q <= DEST_SH;
    end else if (req_i) begin
      dest_q <= dest_i;
    end
  end

  always_comb begin
    case (dest_q)
      DEST_SH: begin
        r_valid_o = sh_r_valid_i;
        r_rdata_o = sh_r_rdata_i;
        r_opc_o   = 1'b0;  // TCDM never flags an error
      end
      DEST_PE: begin
        r_valid_o = pe_r_valid_i;
        r_rdata_o = pe_r_rdata_i;
        r_opc_o   = pe_r_opc_i;
      end
      DEST_EXT: begin
        r_valid_o = ext_r_valid_i;
        r_rdata_o = ext_r_rdata_i;
        r_opc_o   = ext_r_opc_i;
      end
      default: begin
        r_valid_o = 1'b0;
        r_rdata_o = '0;
        r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

/* hw/dest_decoder.sv */
// Request destination decoder
`timescale 1ns/10ps
`include "demux_cfg.svh"

module dest_decoder (
  input  logic [`DEMUX_ADDR_WIDTH-1:0] addr_i,
  input  logic [`DEMUX_CID_WIDTH-1:0]  cluster_id_i,
  output demux_pkg::dest_e             dest_o
);

  import demux_pkg::*;

  logic [11:0] region;
  logic [11:0] tcdm_rw;
  logic [11:0] tcdm_ts;
  logic [11:0] dem_per;
  logic [11:0] alias_rw;
  logic [11:0] alias_ts;
  logic [11:0] alias_per;
  logic        alias_en;
  logic        is_sh;
  logic        is_per;
  logic        is_ext_win;

  assign region = addr_i[31:20];

  // Each cluster owns four 1 MiB slots above the TCDM base
  assign tcdm_rw = `DEMUX_TCDM_BASE + {4'b0000, cluster_id_i, 2'b00};
  assign tcdm_ts = tcdm_rw + 12'd1;
  assign dem_per = tcdm_rw + 12'd2;

  assign alias_en  = `DEMUX_ALIAS_EN;
  assign alias_rw  = `DEMUX_ALIAS_BASE;
  assign alias_ts  = alias_rw + 12'd1;
  assign alias_per = alias_rw + 12'd2;

  // TCDM read/write and test-and-set regions, own or aliased
  assign is_sh = (region == tcdm_rw) || (region == tcdm_ts) ||
                 (alias_en && ((region == alias_rw) || (region == alias_ts)));

  // Peripheral region of this cluster
  assign is_per = (region == dem_per) || (alias_en && (region == alias_per));

  assign is_ext_win = (addr_i[19:10] == `DEMUX_EXT_WINDOW);

  always_comb begin
    if (is_sh) begin
      dest_o = DEST_SH;
    end else if (is_per && is_ext_win) begin
      dest_o = DEST_EXT;
    end else begin
      // Rest of the peripheral region and everything unmapped
      dest_o = DEST_PE;
    end
  end

endmodule

/* hw/addr_remap.sv */
// Address nibble remap
`timescale 1ns/10ps
`include "demux_cfg.svh"

module addr_remap (
  input  logic [`DEMUX_ADDR_WIDTH-1:0] addr_i,
  input  logic [`DEMUX_BASE_WIDTH-1:0] base_addr_i,
  output logic [`DEMUX_ADDR_WIDTH-1:0] addr_o
);

  logic [`DEMUX_BASE_WIDTH-1:0] nibble_in;
  logic [`DEMUX_BASE_WIDTH-1:0] nibble_out;
  logic [`DEMUX_BASE_WIDTH-1:0] one_nibble;

  assign nibble_in  = addr_i[`DEMUX_ADDR_WIDTH-1 -: `DEMUX_BASE_WIDTH];
  assign one_nibble = {{(`DEMUX_BASE_WIDTH-1){1'b0}}, 1'b1};

  // Swap the cluster base nibble with nibble 1
  always_comb begin
    if (nibble_in == base_addr_i) begin
      nibble_out = one_nibble;
    end else if (nibble_in == one_nibble) begin
      nibble_out = base_addr_i;
    end else begin
      nibble_out = nibble_in;
    end
  end

  assign addr_o = {nibble_out, addr_i[`DEMUX_ADDR_WIDTH-`DEMUX_BASE_WIDTH-1:0]};

endmodule

/* hw/demux_pkg.sv */
// Core demux types
package demux_pkg;

  // Target of a core request
  typedef enum logic [1:0] {
    DEST_SH,
    DEST_PE,
    DEST_EXT
  } dest_e;

  // Peripheral port handshake
  typedef enum logic [1:0] {
    PE_IDLE,
    PE_PENDING,
    PE_GRANTED
  } pe_state_e;

endpackage

/* hw/demux_cfg.svh */
// Core demux configuration
`ifndef DEMUX_CFG_SVH
`define DEMUX_CFG_SVH

// Bus widths
`define DEMUX_ADDR_WIDTH 32
`define DEMUX_DATA_WIDTH 32
`define DEMUX_BE_WIDTH (`DEMUX_DATA_WIDTH / 8)

// Cluster identification
`define DEMUX_CID_WIDTH 6
`define DEMUX_BASE_WIDTH 4

// Cluster-local space starts at this base plus four times the cluster id
`define DEMUX_TCDM_BASE 12'h100

// Cluster alias region
`define DEMUX_ALIAS_EN 1'b1
`define DEMUX_ALIAS_BASE 12'h000

// Value of address bits 19:10 that selects the demux peripherals
`define DEMUX_EXT_WINDOW 10'b0000010000

`endif
